// ==== verilog/cache_pkg.sv ====
/*
 * Cache subsystem package
 * Shared bus widths, direct-mapped cache geometry, backing memory
 * size and latency, and the cache controller state encoding.
 */
package cache_pkg;

    // core bus, word addressed
    localparam int addr_bits = 19;
    localparam int data_bits = 16;

    // line geometry
    localparam int line_words = 8;
    localparam int word_sel_bits = 3;

    // 64 lines of 8 words each, 1 KiB of cache
    localparam int cache_lines = 64;
    localparam int index_bits = 6;
    localparam int tag_bits = addr_bits - word_sel_bits - index_bits;

    // backing store, upper address bits wrap
    localparam int mem_words = 4096;
    localparam int mem_addr_bits = 12;

    // cycles between the sampled request and the ack
    localparam int mem_wait_states = 2;

    // controller states
    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_flush,
        st_fill
    } cache_state_e;

endpackage

// ==== verilog/dp_ram.sv ====
`timescale 1ns/1ps
/*
 * Dual-port synchronous RAM
 * Two independent read/write ports, read-first, one cycle of read
 * latency. Used for the cache tag and dirty arrays.
 */
module dp_ram #(
    parameter int words = 64,
    parameter int width = 1
) (
    input  logic                     clk,
    // port a
    input  logic [$clog2(words)-1:0] addr_a,
    input  logic                     wr_en_a,
    input  logic [width-1:0]         wdata_a,
    output logic [width-1:0]         q_a,
    // port b
    input  logic [$clog2(words)-1:0] addr_b,
    input  logic                     wr_en_b,
    input  logic [width-1:0]         wdata_b,
    output logic [width-1:0]         q_b
);

    logic [width-1:0] mem [words];

    // reads see the contents from before this edge's writes
    always_ff @(posedge clk) begin
        q_a <= mem[addr_a];
        q_b <= mem[addr_b];
        if (wr_en_a) begin
            mem[addr_a] <= wdata_a;
        end
        if (wr_en_b) begin
            mem[addr_b] <= wdata_b;
        end
    end

endmodule

// ==== verilog/line_ram.sv ====
`timescale 1ns/1ps
/*
 * Cache line data RAM
 * Dual-port 16-bit storage for all cache lines with a byte enable
 * per lane and port. Port a serves the core, port b the line
 * fills and flushes.
 */
module line_ram (
    input  logic                                                  clk,
    // core port
    input  logic [cache_pkg::index_bits+cache_pkg::word_sel_bits-1:0] addr_a,
    input  logic                                                  wr_en_a,
    input  logic [cache_pkg::data_bits-1:0]                       wdata_a,
    input  logic [1:0]                                            be_a,
    output logic [cache_pkg::data_bits-1:0]                       q_a,
    // fill and flush port
    input  logic [cache_pkg::index_bits+cache_pkg::word_sel_bits-1:0] addr_b,
    input  logic                                                  wr_en_b,
    input  logic [cache_pkg::data_bits-1:0]                       wdata_b,
    input  logic [1:0]                                            be_b,
    output logic [cache_pkg::data_bits-1:0]                       q_b
);

    // two byte lanes per word
    logic [1:0][7:0] mem [cache_pkg::cache_lines * cache_pkg::line_words];

    always_ff @(posedge clk) begin
        q_a <= mem[addr_a];
        q_b <= mem[addr_b];
        for (int lane = 0; lane < 2; lane++) begin
            if (wr_en_a && be_a[lane]) begin
                mem[addr_a][lane] <= wdata_a[8*lane +: 8];
            end
            if (wr_en_b && be_b[lane]) begin
                mem[addr_b][lane] <= wdata_b[8*lane +: 8];
            end
        end
    end

endmodule

// ==== verilog/cache_ctrl.sv ====
`timescale 1ns/1ps
/*
 * Direct-mapped write-back cache controller
 * Write-allocate, 8-word lines. A miss on a dirty line writes the old
 * line back before fetching the new one; words of a line being filled
 * are answered as soon as they arrive. With enabled low the core bus
 * is passed straight to memory.
 */
module cache_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           enabled,
    // core side
    input  logic [cache_pkg::addr_bits-1:0] c_addr,
    input  logic [cache_pkg::data_bits-1:0] c_data_out,
    input  logic                           c_access,
    input  logic                           c_wr_en,
    input  logic [1:0]                     c_bytesel,
    output logic [cache_pkg::data_bits-1:0] c_data_in,
    output logic                           c_ack,
    // memory side
    output logic [cache_pkg::addr_bits-1:0] m_addr,
    output logic [cache_pkg::data_bits-1:0] m_data_out,
    output logic                           m_access,
    output logic                           m_wr_en,
    output logic [1:0]                     m_bytesel,
    input  logic [cache_pkg::data_bits-1:0] m_data_in,
    input  logic                           m_ack
);

    cache_pkg::cache_state_e state;

    logic                                 ack_q;
    logic [cache_pkg::cache_lines-1:0]    valid;
    logic [cache_pkg::line_words-1:0]     arrived;
    logic [cache_pkg::word_sel_bits-1:0]  beat;
    logic [cache_pkg::word_sel_bits-1:0]  beat_rd;
    logic [cache_pkg::index_bits-1:0]     line_idx;
    logic [cache_pkg::tag_bits-1:0]       fill_tag;
    logic [cache_pkg::tag_bits-1:0]       victim_tag;

    logic [cache_pkg::word_sel_bits-1:0]  c_word;
    logic [cache_pkg::index_bits-1:0]     c_idx;
    logic [cache_pkg::tag_bits-1:0]       c_tag;
    logic [cache_pkg::tag_bits-1:0]       tag_q;
    logic                                 dirty_q;
    logic [cache_pkg::data_bits-1:0]      c_q;
    logic [cache_pkg::data_bits-1:0]      flush_data;

    logic accept;
    logic hit;
    logic same_line;
    logic fill_ack;
    logic ack_set;
    logic last_beat;
    logic flush_done;
    logic fill_start;
    logic fill_write;

    // request address split into tag, index and word
    assign c_word = c_addr[cache_pkg::word_sel_bits-1:0];
    assign c_idx  = c_addr[cache_pkg::word_sel_bits +: cache_pkg::index_bits];
    assign c_tag  = c_addr[cache_pkg::addr_bits-1 -: cache_pkg::tag_bits];

    // the edge that ends an ack cycle still sees the old request
    assign accept = enabled && c_access && !ack_q;

    assign hit = valid[c_idx] && (tag_q == c_tag);

    // early answer from the line currently filling
    assign same_line = (c_idx == line_idx) && (c_tag == fill_tag);
    assign fill_ack  = (state == cache_pkg::st_fill) && c_access && !ack_q &&
                       same_line && arrived[c_word];

    assign ack_set    = ((state == cache_pkg::st_lookup) && hit) || fill_ack;
    assign last_beat  = &beat;
    assign flush_done = (state == cache_pkg::st_flush) && m_ack && last_beat;
    assign fill_start = ((state == cache_pkg::st_lookup) && !hit &&
                         !(valid[c_idx] && dirty_q)) || flush_done;
    assign fill_write = (state == cache_pkg::st_fill) && m_ack;

    // flush reads one word ahead so data is ready for the next beat
    assign beat_rd = ((state == cache_pkg::st_flush) && m_ack) ? beat + 1'b1 : beat;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= cache_pkg::st_idle;
            ack_q   <= 1'b0;
            valid   <= '0;
            arrived <= '0;
            beat    <= '0;
        end else begin
            ack_q <= ack_set;
            case (state)
                cache_pkg::st_idle: begin
                    if (accept) begin
                        state <= cache_pkg::st_lookup;
                    end
                end
                cache_pkg::st_lookup: begin
                    beat <= '0;
                    if (hit) begin
                        state <= cache_pkg::st_idle;
                    end else if (fill_start) begin
                        state <= cache_pkg::st_fill;
                    end else begin
                        state <= cache_pkg::st_flush;
                    end
                end
                cache_pkg::st_flush: begin
                    if (m_ack) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            state <= cache_pkg::st_fill;
                        end
                    end
                end
                cache_pkg::st_fill: begin
                    if (m_ack) begin
                        arrived[beat] <= 1'b1;
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            valid[line_idx] <= 1'b1;
                            state <= cache_pkg::st_idle;
                        end
                    end
                end
                default: begin
                    state <= cache_pkg::st_idle;
                end
            endcase
            // the line is invalid while its tag and data are replaced
            if (fill_start) begin
                arrived <= '0;
                valid[line_idx] <= 1'b0;
            end
        end
    end

    // capture the line to replace when a request is taken
    always_ff @(posedge clk) begin
        if ((state == cache_pkg::st_idle) && accept) begin
            line_idx <= c_idx;
            fill_tag <= c_tag;
        end
        if (state == cache_pkg::st_lookup) begin
            victim_tag <= tag_q;
        end
    end

    dp_ram #(
        .words(cache_pkg::cache_lines),
        .width(cache_pkg::tag_bits)
    ) tag_ram (
        .clk(clk),
        .addr_a(c_idx),
        .wr_en_a(1'b0),
        .wdata_a({cache_pkg::tag_bits{1'b0}}),
        .q_a(tag_q),
        .addr_b(line_idx),
        .wr_en_b(fill_start),
        .wdata_b(fill_tag),
        .q_b()
    );

    // set by core writes, cleared as a fill begins
    dp_ram #(
        .words(cache_pkg::cache_lines),
        .width(1)
    ) dirty_ram (
        .clk(clk),
        .addr_a(c_idx),
        .wr_en_a(ack_set && c_wr_en),
        .wdata_a(1'b1),
        .q_a(dirty_q),
        .addr_b(line_idx),
        .wr_en_b(fill_start),
        .wdata_b(1'b0),
        .q_b()
    );

    line_ram data_ram (
        .clk(clk),
        .addr_a({c_idx, c_word}),
        .wr_en_a(ack_set && c_wr_en),
        .wdata_a(c_data_out),
        .be_a(c_bytesel),
        .q_a(c_q),
        .addr_b({line_idx, beat_rd}),
        .wr_en_b(fill_write),
        .wdata_b(m_data_in),
        .be_b(2'b11),
        .q_b(flush_data)
    );

    always_comb begin
        if (enabled) begin
            c_ack      = ack_q;
            c_data_in  = ack_q ? c_q : '0;
            m_access   = ((state == cache_pkg::st_flush) ||
                          (state == cache_pkg::st_fill)) && !m_ack;
            m_wr_en    = (state == cache_pkg::st_flush) && !m_ack;
            m_addr     = {((state == cache_pkg::st_flush) ? victim_tag : fill_tag),
                          line_idx, beat};
            m_data_out = flush_data;
            m_bytesel  = 2'b11;
        end else begin
            // bypass
            c_ack      = m_ack;
            c_data_in  = m_data_in;
            m_access   = c_access;
            m_wr_en    = c_wr_en;
            m_addr     = c_addr;
            m_data_out = c_data_out;
            m_bytesel  = c_bytesel;
        end
    end

    a_no_access_from_idle: assert property (@(posedge clk) disable iff (!rst_n)
        enabled && $rose(m_access) |-> $past(state) != cache_pkg::st_idle)
        else $error("memory access started from idle");

    a_ack_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
        c_ack |-> $past(c_access))
        else $error("c_ack without a pending request");

    a_write_only_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
        enabled && m_wr_en |-> (state == cache_pkg::st_flush) && valid[line_idx])
        else $error("memory write outside the flush of a valid line");

endmodule

// ==== verilog/backing_mem.sv ====
`timescale 1ns/1ps
/*
 * Main memory model
 * Word-wide SRAM behind a wait-state controller. Each access is
 * acknowledged a fixed number of cycles after it is sampled; writes
 * honour the byte selects.
 */
module backing_mem (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [cache_pkg::addr_bits-1:0] m_addr,
    input  logic [cache_pkg::data_bits-1:0] m_data_out,
    input  logic                            m_access,
    input  logic                            m_wr_en,
    input  logic [1:0]                      m_bytesel,
    output logic [cache_pkg::data_bits-1:0] m_data_in,
    output logic                            m_ack
);

    logic [1:0][7:0] mem [cache_pkg::mem_words];

    logic                                busy;
    logic [3:0]                          wait_cnt;
    logic                                done;
    logic [cache_pkg::mem_addr_bits-1:0] word_addr;

    // high address bits alias onto the store
    assign word_addr = m_addr[cache_pkg::mem_addr_bits-1:0];
    assign done      = busy && (wait_cnt == 4'(cache_pkg::mem_wait_states));

    initial begin
        for (int i = 0; i < cache_pkg::mem_words; i++) begin
            mem[i] = '0;
        end
    end

    // wait-state sequencer, one access at a time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            wait_cnt <= '0;
            m_ack    <= 1'b0;
        end else begin
            m_ack <= done;
            if (done) begin
                busy <= 1'b0;
            end else if (busy) begin
                wait_cnt <= wait_cnt + 1'b1;
            end else if (m_access && !m_ack) begin
                // access held through its ack cycle is not a new one
                busy     <= 1'b1;
                wait_cnt <= '0;
            end
        end
    end

    // storage updates in the ack cycle
    always @(posedge clk) begin
        if (done) begin
            m_data_in <= mem[word_addr];
            for (int lane = 0; lane < 2; lane++) begin
                if (m_wr_en && m_bytesel[lane]) begin
                    mem[word_addr][lane] <= m_data_out[8*lane +: 8];
                end
            end
        end
    end

    a_single_access: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> m_access && $stable(m_addr))
        else $error("new memory access while one is in progress");

endmodule

// ==== verilog/cached_mem_top.sv ====
`timescale 1ns/1ps
/*
 * Cached memory subsystem
 * Cache controller in front of the wait-state main memory model.
 */
module cached_mem_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            enabled,
    input  logic [cache_pkg::addr_bits-1:0] c_addr,
    input  logic [cache_pkg::data_bits-1:0] c_data_out,
    input  logic                            c_access,
    input  logic                            c_wr_en,
    input  logic [1:0]                      c_bytesel,
    output logic [cache_pkg::data_bits-1:0] c_data_in,
    output logic                            c_ack
);

    // cache to memory
    logic [cache_pkg::addr_bits-1:0] m_addr;
    logic [cache_pkg::data_bits-1:0] m_data_out;
    logic [cache_pkg::data_bits-1:0] m_data_in;
    logic                            m_access;
    logic                            m_wr_en;
    logic [1:0]                      m_bytesel;
    logic                            m_ack;

    cache_ctrl u_cache_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .enabled(enabled),
        .c_addr(c_addr),
        .c_data_out(c_data_out),
        .c_access(c_access),
        .c_wr_en(c_wr_en),
        .c_bytesel(c_bytesel),
        .c_data_in(c_data_in),
        .c_ack(c_ack),
        .m_addr(m_addr),
        .m_data_out(m_data_out),
        .m_access(m_access),
        .m_wr_en(m_wr_en),
        .m_bytesel(m_bytesel),
        .m_data_in(m_data_in),
        .m_ack(m_ack)
    );

    backing_mem u_backing_mem (
        .clk(clk),
        .rst_n(rst_n),
        .m_addr(m_addr),
        .m_data_out(m_data_out),
        .m_access(m_access),
        .m_wr_en(m_wr_en),
        .m_bytesel(m_bytesel),
        .m_data_in(m_data_in),
        .m_ack(m_ack)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps
/*
 * Testbench clock and reset source
 * 40 ns clock and an active-low reset held over the first 8 rising edges.
 */
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period_ns = 20;
    localparam int reset_cycles = 8;

    initial begin
        clk = 1'b0;
        forever #(half_period_ns) clk = ~clk;
    end

    // released between the drive and sample points of the testbench
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #5;
        rst_n = 1'b1;
    end

endmodule

// ==== tests/tb_cached_mem.sv ====
`timescale 1ns/1ps
/*
 * Testbench for the cached memory subsystem
 * Replays core bus operations from a vector file, checks read data and
 * hit latency, and closes with an error summary.
 */
module tb_cached_mem;

    localparam int fields = 7;
    localparam int max_vectors = 64;
    localparam int ack_timeout = 2000;
    localparam int reset_timeout = 100;
    localparam int hit_cycles = 2;

    logic                            clk;
    logic                            rst_n;
    logic                            enabled;
    logic [cache_pkg::addr_bits-1:0] c_addr;
    logic [cache_pkg::data_bits-1:0] c_data_out;
    logic                            c_access;
    logic                            c_wr_en;
    logic [1:0]                      c_bytesel;
    logic [cache_pkg::data_bits-1:0] c_data_in;
    logic                            c_ack;

    // seven hex fields per operation
    logic [31:0] vec_mem [fields*max_vectors];

    int unsigned                     seed;
    int unsigned                     rand_init;
    int                              value_errors;
    int                              timing_errors;
    int                              other_errors;
    int                              n_vec;
    int                              idx;
    bit                              timed_out;
    bit                              prev_cached_read;
    logic [cache_pkg::addr_bits-1:0] prev_addr;

    tb_clock_gen u_clock_gen (
        .clk(clk),
        .rst_n(rst_n)
    );

    cached_mem_top uut (
        .clk(clk),
        .rst_n(rst_n),
        .enabled(enabled),
        .c_addr(c_addr),
        .c_data_out(c_data_out),
        .c_access(c_access),
        .c_wr_en(c_wr_en),
        .c_bytesel(c_bytesel),
        .c_data_in(c_data_in),
        .c_ack(c_ack)
    );

    function automatic string test_name(input logic [31:0] num);
        case (num)
            1: return "after_reset";
            2: return "write_allocate";
            3: return "byte_merge";
            4: return "eviction";
            5: return "bypass";
            6: return "fill_reads";
            default: return "unknown";
        endcase
    endfunction

    // c_ack low through reset and the first idle cycles after it
    task automatic check_reset_ack();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < reset_timeout) begin
            @(posedge clk);
            #1;
            cycles++;
            if (c_ack !== 1'b0) begin
                $display("[ERROR] %s: c_ack expected 0, actual %b", test_name(1), c_ack);
                value_errors++;
            end
        end
        if (rst_n !== 1'b1) begin
            $display("reset was not released within %0d cycles", reset_timeout);
            other_errors++;
            timed_out = 1'b1;
        end
        repeat (4) begin
            @(posedge clk);
            #1;
            if (c_ack !== 1'b0) begin
                $display("[ERROR] %s: c_ack expected 0, actual %b", test_name(1), c_ack);
                value_errors++;
            end
        end
    endtask

    task automatic run_vector(input int n);
        logic [31:0] num;
        logic        en;
        logic        wr;
        logic [31:0] addr;
        logic [1:0]  bsel;
        logic [15:0] wdata;
        logic [15:0] expected;
        int          gap;
        int          cycles;
        bit          got_ack;
        bit          check_hit;
        num      = vec_mem[n*fields];
        en       = vec_mem[n*fields+1][0];
        wr       = vec_mem[n*fields+2][0];
        addr     = vec_mem[n*fields+3];
        bsel     = vec_mem[n*fields+4][1:0];
        wdata    = vec_mem[n*fields+5][15:0];
        expected = vec_mem[n*fields+6][15:0];
        // a cached read repeating the previous cached read hits a resident line
        check_hit = en && !wr && prev_cached_read &&
                    (addr[cache_pkg::addr_bits-1:0] == prev_addr);

        gap = $urandom % 4;
        if (gap > 0) begin
            c_access = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
        enabled    = en;
        c_addr     = addr[cache_pkg::addr_bits-1:0];
        c_wr_en    = wr;
        c_data_out = wdata;
        c_bytesel  = bsel;
        c_access   = 1'b1;

        cycles  = 0;
        got_ack = 1'b0;
        while (!got_ack && cycles < ack_timeout) begin
            @(posedge clk);
            #1;
            cycles++;
            got_ack = (c_ack === 1'b1);
        end
        if (!got_ack) begin
            $display("timeout: vector %0d (%s) got no c_ack within %0d cycles",
                     n, test_name(num), ack_timeout);
            other_errors++;
            timed_out = 1'b1;
        end else begin
            if (!wr && c_data_in !== expected) begin
                $display("[ERROR] %s vector %0d addr %h: expected %h, actual %h",
                         test_name(num), n, c_addr, expected, c_data_in);
                value_errors++;
            end
            if (check_hit && cycles != hit_cycles) begin
                $display("[ERROR] %s vector %0d hit latency: expected %0d, actual %0d",
                         test_name(num), n, hit_cycles, cycles);
                timing_errors++;
            end
            // request stays on the bus through the ack cycle
            @(posedge clk);
            #1;
        end
        prev_cached_read = en && !wr;
        prev_addr        = addr[cache_pkg::addr_bits-1:0];
    endtask

    initial begin
        enabled          = 1'b1;
        c_addr           = '0;
        c_data_out       = '0;
        c_access         = 1'b0;
        c_wr_en          = 1'b0;
        c_bytesel        = 2'b11;
        value_errors     = 0;
        timing_errors    = 0;
        other_errors     = 0;
        timed_out        = 1'b0;
        prev_cached_read = 1'b0;
        prev_addr        = '0;
        seed             = 32'hda3e_aa9a;
        rand_init        = $urandom(seed);

        $readmemh("tests/cache_vectors.txt", vec_mem);
        n_vec = 0;
        while (n_vec < max_vectors && vec_mem[n_vec*fields] !== {32{1'bx}}) begin
            n_vec++;
        end
        if (n_vec == 0) begin
            $display("no operations were loaded from tests/cache_vectors.txt");
            other_errors++;
        end

        check_reset_ack();
        idx = 0;
        while (idx < n_vec && !timed_out) begin
            run_vector(idx);
            idx++;
        end
        c_access = 1'b0;

        $display("errors: %0d value, %0d timing, %0d other over %0d operations",
                 value_errors, timing_errors, other_errors, idx);
        if (value_errors + timing_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/cache_vectors.txt ====
// columns (hex): test enabled write word_addr bytesel wdata expected_rdata
// tests: 2 write allocate, 3 byte merge, 4 eviction, 5 bypass, 6 reads during a fill
05 0 1 00100 3 0f01 0000
05 0 1 00102 3 2d23 0000
05 0 1 00103 3 3c34 0000
05 0 1 00105 3 5a56 0000
05 0 1 00107 3 7878 0000
05 0 1 00103 1 55aa 0000
05 0 1 00106 2 c3ff 0000
05 0 0 00103 3 0000 3caa
05 0 0 00106 3 0000 c300
05 0 0 00200 3 0000 0000
02 1 1 00040 3 1234 0000
02 1 0 00041 3 0000 0000
02 1 0 00042 3 0000 0000
02 1 0 00043 3 0000 0000
02 1 0 00044 3 0000 0000
02 1 0 00045 3 0000 0000
02 1 0 00046 3 0000 0000
02 1 0 00047 3 0000 0000
02 1 0 00040 3 0000 1234
02 1 0 00040 3 0000 1234
03 1 1 00080 3 a5c3 0000
03 1 1 00080 2 7eff 0000
03 1 0 00080 3 0000 7ec3
03 1 1 00080 1 9966 0000
03 1 0 00080 3 0000 7e66
04 1 1 00060 3 beef 0000
04 1 1 00063 3 0f0f 0000
04 1 0 00260 3 0000 0000
04 1 1 00265 3 4321 0000
04 1 0 00060 3 0000 beef
04 1 0 00063 3 0000 0f0f
04 1 0 00265 3 0000 4321
06 1 0 00100 3 0000 0f01
06 1 0 00101 3 0000 0000
06 1 0 00102 3 0000 2d23
06 1 0 00103 3 0000 3caa
06 1 0 00104 3 0000 0000
06 1 0 00105 3 0000 5a56
06 1 0 00106 3 0000 c300
06 1 0 00107 3 0000 7878
06 1 0 00100 3 0000 0f01
06 1 0 00100 3 0000 0f01

// ==== vlog.f ====
verilog/cache_pkg.sv
verilog/dp_ram.sv
verilog/line_ram.sv
verilog/cache_ctrl.sv
verilog/backing_mem.sv
verilog/cached_mem_top.sv
tests/tb_clock_gen.sv
tests/tb_cached_mem.sv

// ==== Bender.yml ====
package:
  name: cached_mem

sources:
  # design, package first
  - verilog/cache_pkg.sv
  - verilog/dp_ram.sv
  - verilog/line_ram.sv
  - verilog/cache_ctrl.sv
  - verilog/backing_mem.sv
  - verilog/cached_mem_top.sv

  # testbench
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_cached_mem.sv
